//--- Makefile
TOP = tcu_dot_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f tcu_dot.f

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Regression passed"

clean:
	rm -rf obj_dir

//--- hdl/tcu_align_add.sv
// **********************************************************************
// Aligns every term to the common exponent and forms the signed sum
// **********************************************************************
`default_nettype none

module tcu_align_add #(
    parameter int N = 5,
    localparam int SUM_W = 25 + tcu_pkg::FRAC_GUARD + $clog2(N) + 1
) (
    input  wire tcu_pkg::term_t [N-1:0]  terms,
    input  wire tcu_pkg::shamt_t [N-1:0] shifts,
    output logic signed [SUM_W-1:0]      sum
);

    // zero headroom above sig, guard fraction below
    localparam int PAD_W = SUM_W - 25 - tcu_pkg::FRAC_GUARD;

    logic [SUM_W-1:0] shifted;
    logic [SUM_W-1:0] acc;

    always_comb begin
        acc     = '0;
        shifted = '0;
        for (int i = 0; i < N; i++) begin
            // bits past the guard fraction are lost
            shifted = {{PAD_W{1'b0}}, terms[i].sig, {tcu_pkg::FRAC_GUARD{1'b0}}} >> shifts[i];
            if (terms[i].sign) begin
                acc = acc - shifted;
            end else begin
                acc = acc + shifted;
            end
        end
        sum = signed'(acc);
    end

endmodule

`default_nettype wire

//--- hdl/tcu_dot_top.sv
// **********************************************************************
// Tensor core dot-product unit with four-phase req/ack host interface
// **********************************************************************
`default_nettype none

module tcu_dot_top #(
    parameter int N = 5
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         req,
    input  wire tcu_pkg::fmt_e          fmt,
    input  wire tcu_pkg::half_t [N-2:0] a_rows,
    input  wire tcu_pkg::half_t [N-2:0] b_cols,
    input  wire tcu_pkg::word_t         c_val,
    output logic                        ack,
    output tcu_pkg::word_t              result,
    output tcu_pkg::exc_t               exceptions
);

    localparam int SUM_W = 25 + tcu_pkg::FRAC_GUARD + $clog2(N) + 1;

    tcu_pkg::ctl_state_e state;
    // second BUSY cycle marker
    logic                stage_vld;

    // operand registers
    tcu_pkg::fmt_e           fmt_q;
    tcu_pkg::half_t [N-2:0]  a_q;
    tcu_pkg::half_t [N-2:0]  b_q;
    tcu_pkg::word_t          c_q;

    // front end outputs and their stage register
    tcu_pkg::term_t [N-1:0]  terms;
    tcu_pkg::exp_t           max_exp;
    tcu_pkg::shamt_t [N-1:0] shifts;
    tcu_pkg::exc_t           exc;
    tcu_pkg::term_t [N-1:0]  terms_q;
    tcu_pkg::exp_t           max_exp_q;
    tcu_pkg::shamt_t [N-1:0] shifts_q;
    tcu_pkg::exc_t           exc_q;

    logic signed [SUM_W-1:0] sum;
    tcu_pkg::word_t          nrm_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= tcu_pkg::S_IDLE;
            stage_vld  <= 1'b0;
            ack        <= 1'b0;
            result     <= '0;
            exceptions <= '0;
        end else begin
            case (state)
                tcu_pkg::S_IDLE: begin
                    if (req) begin
                        state     <= tcu_pkg::S_BUSY;
                        stage_vld <= 1'b0;
                    end
                end
                tcu_pkg::S_BUSY: begin
                    if (!stage_vld) begin
                        stage_vld <= 1'b1;
                    end else begin
                        // align, add and normalize land here
                        result     <= nrm_result;
                        exceptions <= exc_q;
                        ack        <= 1'b1;
                        stage_vld  <= 1'b0;
                        state      <= tcu_pkg::S_DONE;
                    end
                end
                tcu_pkg::S_DONE: begin
                    // hold result until the host drops req
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= tcu_pkg::S_IDLE;
                    end
                end
                default: state <= tcu_pkg::S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == tcu_pkg::S_IDLE && req) begin
            fmt_q <= fmt;
            a_q   <= a_rows;
            b_q   <= b_cols;
            c_q   <= c_val;
        end
        if (state == tcu_pkg::S_BUSY && !stage_vld) begin
            terms_q   <= terms;
            max_exp_q <= max_exp;
            shifts_q  <= shifts;
            exc_q     <= exc;
        end
    end

    tcu_mul_exp #(
        .N (N)
    ) u_mul_exp (
        .fmt        (fmt_q),
        .a_rows     (a_q),
        .b_cols     (b_q),
        .c_val      (c_q),
        .terms      (terms),
        .max_exp    (max_exp),
        .shifts     (shifts),
        .exceptions (exc)
    );

    tcu_align_add #(
        .N (N)
    ) u_align_add (
        .terms  (terms_q),
        .shifts (shifts_q),
        .sum    (sum)
    );

    tcu_normalize #(
        .N (N)
    ) u_normalize (
        .sum     (sum),
        .max_exp (max_exp_q),
        .exc_in  (exc_q),
        .result  (nrm_result)
    );

endmodule

`default_nettype wire

//--- hdl/tcu_max_exp.sv
// **********************************************************************
// Largest term exponent and per-term alignment shift
// **********************************************************************
`default_nettype none

module tcu_max_exp #(
    parameter int N = 5
) (
    input  wire tcu_pkg::exp_t [N-1:0] exps,
    output tcu_pkg::exp_t              max_exp,
    output tcu_pkg::shamt_t [N-1:0]    shifts
);

    // zero terms carry exponent 0 and never win
    always_comb begin
        max_exp = '0;
        for (int i = 0; i < N; i++) begin
            if (exps[i] > max_exp) begin
                max_exp = exps[i];
            end
        end
    end

    // distance below the max, zero terms shift out harmlessly
    for (genvar i = 0; i < N; i++) begin : g_shift
        assign shifts[i] = max_exp - exps[i];
    end

endmodule

`default_nettype wire

//--- hdl/tcu_mul_exp.sv
// **********************************************************************
// Dot-product front end: product lanes, addend term, max exponent and
// exception flags
// **********************************************************************
`default_nettype none

module tcu_mul_exp #(
    parameter int N = 5
) (
    input  wire tcu_pkg::fmt_e          fmt,
    input  wire tcu_pkg::half_t [N-2:0] a_rows,
    input  wire tcu_pkg::half_t [N-2:0] b_cols,
    input  wire tcu_pkg::word_t         c_val,
    output tcu_pkg::term_t [N-1:0]      terms,
    output tcu_pkg::exp_t               max_exp,
    output tcu_pkg::shamt_t [N-1:0]     shifts,
    output tcu_pkg::exc_t               exceptions
);

    tcu_pkg::exp_t [N-1:0] exps;

    // one multiply lane per row/column pair
    for (genvar i = 0; i < N - 1; i++) begin : g_lane
        tcu_prod_mul u_prod (
            .fmt  (fmt),
            .a    (a_rows[i]),
            .b    (b_cols[i]),
            .term (terms[i])
        );
    end

    // addend is the last term
    assign terms[N-1].sign = c_val[31];
    assign terms[N-1].exp  = c_val[30:23];
    // zero exponent flushes, all-ones keeps an inf addend dominant
    assign terms[N-1].sig  = (c_val[30:23] == 8'h00) ? '0 :
                             (c_val[30:23] == 8'hff) ? '1 :
                             {1'b0, 1'b1, c_val[22:0]};

    for (genvar i = 0; i < N; i++) begin : g_exp
        assign exps[i] = terms[i].exp;
    end

    // max search runs beside the multipliers
    tcu_max_exp #(
        .N (N)
    ) u_max_exp (
        .exps    (exps),
        .max_exp (max_exp),
        .shifts  (shifts)
    );

    tcu_nan_inf #(
        .N (N)
    ) u_nan_inf (
        .fmt        (fmt),
        .a_rows     (a_rows),
        .b_cols     (b_cols),
        .c_val      (c_val),
        .exceptions (exceptions)
    );

endmodule

`default_nettype wire

//--- hdl/tcu_nan_inf.sv
// **********************************************************************
// NaN, infinity and invalid-operation detection over all operands
// **********************************************************************
`default_nettype none

module tcu_nan_inf #(
    parameter int N = 5
) (
    input  wire tcu_pkg::fmt_e          fmt,
    input  wire tcu_pkg::half_t [N-2:0] a_rows,
    input  wire tcu_pkg::half_t [N-2:0] b_cols,
    input  wire tcu_pkg::word_t         c_val,
    output tcu_pkg::exc_t               exceptions
);

    // {nan, inf, zero} of one half-width operand
    function automatic logic [2:0] classify(input tcu_pkg::fmt_e f, input tcu_pkg::half_t h);
        logic all_ones;
        logic man_nz;
        logic exp_zero;
        if (f == tcu_pkg::FMT_BF16) begin
            all_ones = &h[14:7];
            man_nz   = |h[6:0];
            exp_zero = ~|h[14:7];
        end else begin
            all_ones = &h[14:10];
            man_nz   = |h[9:0];
            exp_zero = ~|h[14:10];
        end
        return {all_ones & man_nz, all_ones & ~man_nz, exp_zero};
    endfunction

    logic       c_nan;
    logic       c_inf;
    logic [2:0] ca;
    logic [2:0] cb;
    logic       any_nan;
    logic       pos_inf;
    logic       neg_inf;
    logic       inf_zero;

    assign c_nan = (&c_val[30:23]) & (|c_val[22:0]);
    assign c_inf = (&c_val[30:23]) & ~(|c_val[22:0]);

    always_comb begin
        any_nan  = c_nan;
        pos_inf  = c_inf & ~c_val[31];
        neg_inf  = c_inf & c_val[31];
        inf_zero = 1'b0;
        ca       = '0;
        cb       = '0;
        for (int i = 0; i < N - 1; i++) begin
            ca = classify(fmt, a_rows[i]);
            cb = classify(fmt, b_cols[i]);
            any_nan = any_nan | ca[2] | cb[2];
            // infinite product, unless the other side is NaN
            if ((ca[1] | cb[1]) && !(ca[2] | cb[2])) begin
                if (ca[0] | cb[0]) begin
                    inf_zero = 1'b1;
                end else if (a_rows[i][15] ^ b_cols[i][15]) begin
                    neg_inf = 1'b1;
                end else begin
                    pos_inf = 1'b1;
                end
            end
        end
    end

    assign exceptions.nan     = any_nan;
    assign exceptions.inf     = pos_inf | neg_inf;
    // inf * 0, or +inf meeting -inf in the sum
    assign exceptions.invalid = inf_zero | (pos_inf & neg_inf);

endmodule

`default_nettype wire

//--- hdl/tcu_normalize.sv
// **********************************************************************
// Leading-one normalize, truncation to fp32 and exception override
// **********************************************************************
`default_nettype none

module tcu_normalize #(
    parameter int N = 5,
    localparam int SUM_W = 25 + tcu_pkg::FRAC_GUARD + $clog2(N) + 1
) (
    input  wire logic signed [SUM_W-1:0] sum,
    input  wire tcu_pkg::exp_t           max_exp,
    input  wire tcu_pkg::exc_t           exc_in,
    output tcu_pkg::word_t               result
);

    // sum bit that carries weight 2^(max_exp - 127)
    localparam int POINT = 23 + tcu_pkg::FRAC_GUARD;
    localparam tcu_pkg::word_t QNAN = 32'h7fc0_0000;

    logic             neg;
    logic [SUM_W-1:0] mag;
    logic [SUM_W-1:0] norm;
    int               lead;
    int               exp_i;

    always_comb begin
        neg  = sum[SUM_W-1];
        mag  = neg ? -sum : sum;
        lead = 0;
        for (int i = 0; i < SUM_W; i++) begin
            if (mag[i]) begin
                lead = i;
            end
        end
        exp_i = int'(max_exp) + lead - POINT;
        // leading one to the top, mantissa right below it
        norm  = mag << (SUM_W - 1 - lead);

        if (exc_in.nan || exc_in.invalid) begin
            result = QNAN;
        end else if (exc_in.inf) begin
            // inf terms dominate the sum, so its sign is theirs
            result = {neg, 8'hff, 23'h000000};
        end else if (mag == '0) begin
            result = '0;
        end else if (exp_i <= 0) begin
            result = {neg, 31'h00000000};
        end else if (exp_i >= 255) begin
            result = {neg, 8'hff, 23'h000000};
        end else begin
            // truncate, round toward zero
            result = {neg, exp_i[7:0], norm[SUM_W-2 -: 23]};
        end
    end

endmodule

`default_nettype wire

//--- hdl/tcu_pkg.sv
// **********************************************************************
// Tensor core dot-product shared types, structs and format constants
// **********************************************************************
`default_nettype none

package tcu_pkg;

    // raw fp16 / bf16 operand
    typedef logic [15:0] half_t;
    // fp32 value
    typedef logic [31:0] word_t;
    // biased exponent on the fp32 scale
    typedef logic [7:0] exp_t;
    // term significand, binary point below bit 23
    typedef logic [24:0] sig_t;
    // right shift for alignment
    typedef logic [7:0] shamt_t;

    // input operand format
    typedef enum logic {
        FMT_FP16 = 1'b0,
        FMT_BF16 = 1'b1
    } fmt_e;

    // top-level handshake control
    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_BUSY = 2'd1,
        S_DONE = 2'd2
    } ctl_state_e;

    // one product or addend term, value = sig * 2^(exp - 150)
    typedef struct packed {
        logic sign;
        exp_t exp;
        sig_t sig;
    } term_t;

    // exception flags
    typedef struct packed {
        logic nan;
        logic inf;
        logic invalid;
    } exc_t;

    localparam int FP16_BIAS  = 15;
    localparam int BF16_BIAS  = 127;
    // fraction bits kept below each term during alignment
    localparam int FRAC_GUARD = 31;

endpackage

`default_nettype wire

//--- hdl/tcu_prod_mul.sv
// **********************************************************************
// Product lane: significand multiply, exponent add and fp32 rebias
// **********************************************************************
`default_nettype none

module tcu_prod_mul (
    input  wire tcu_pkg::fmt_e  fmt,
    input  wire tcu_pkg::half_t a,
    input  wire tcu_pkg::half_t b,
    output tcu_pkg::term_t      term
);

    logic [7:0]      ea;
    logic [7:0]      eb;
    // significands with hidden one, right aligned
    logic [10:0]     ma;
    logic [10:0]     mb;
    logic [21:0]     prod;
    logic            special;
    int              bias;
    int              exp_i;
    tcu_pkg::sig_t   sig;

    always_comb begin
        if (fmt == tcu_pkg::FMT_BF16) begin
            ea      = a[14:7];
            eb      = b[14:7];
            ma      = {3'b000, 1'b1, a[6:0]};
            mb      = {3'b000, 1'b1, b[6:0]};
            bias    = tcu_pkg::BF16_BIAS;
            special = (&a[14:7]) | (&b[14:7]);
        end else begin
            ea      = {3'b000, a[14:10]};
            eb      = {3'b000, b[14:10]};
            ma      = {1'b1, a[9:0]};
            mb      = {1'b1, b[9:0]};
            bias    = tcu_pkg::FP16_BIAS;
            special = (&a[14:10]) | (&b[14:10]);
        end
        prod = ma * mb;
        // fp16 point sits below bit 20, bf16 below bit 14
        sig   = (fmt == tcu_pkg::FMT_BF16) ? {prod[15:0], 9'h000} : {prod, 3'b000};
        exp_i = int'(ea) + int'(eb) - 2 * bias + 127;

        term.sign = a[15] ^ b[15];
        if (ea == 8'h00 || eb == 8'h00) begin
            // zero operand, subnormals flushed
            term.exp = '0;
            term.sig = '0;
        end else if (special) begin
            // inf/nan lane dominates the sum so its sign survives
            term.exp = 8'hff;
            term.sig = '1;
        end else if (exp_i <= 0) begin
            term.exp = '0;
            term.sig = '0;
        end else if (exp_i >= 255) begin
            term.exp = 8'hff;
            term.sig = sig;
        end else begin
            term.exp = exp_i[7:0];
            term.sig = sig;
        end
    end

endmodule

`default_nettype wire

//--- tcu_dot.f
hdl/tcu_pkg.sv
hdl/tcu_prod_mul.sv
hdl/tcu_max_exp.sv
hdl/tcu_nan_inf.sv
hdl/tcu_mul_exp.sv
hdl/tcu_align_add.sv
hdl/tcu_normalize.sv
hdl/tcu_dot_top.sv
testbench/tcu_dot_tb.sv

//--- testbench/tcu_dot_tb.sv
// **********************************************************************
// Testbench for the dot-product unit: handshake, fp16, bf16, alignment
// and exception tests against an exact integer reference model
// **********************************************************************
`default_nettype none

module tcu_dot_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N        = 5;
    localparam int WAIT_MAX = 20;
    // fp16 special encodings
    localparam tcu_pkg::half_t H_QNAN = 16'h7e00;
    localparam tcu_pkg::half_t H_PINF = 16'h7c00;
    localparam tcu_pkg::half_t H_ONE  = 16'h3c00;
    localparam tcu_pkg::half_t H_MTWO = 16'hc000;
    // fp32 canonical NaN and negative infinity
    localparam tcu_pkg::word_t W_QNAN = 32'h7fc0_0000;
    localparam tcu_pkg::word_t W_NINF = 32'hff80_0000;

    logic                   clk;
    logic                   rst;
    logic                   req;
    tcu_pkg::fmt_e          fmt;
    tcu_pkg::half_t [N-2:0] a_rows;
    tcu_pkg::half_t [N-2:0] b_cols;
    tcu_pkg::word_t         c_val;
    logic                   ack;
    tcu_pkg::word_t         result;
    tcu_pkg::exc_t          exceptions;

    logic [31:0] lfsr_state;
    // integer operands of the current case
    int          av [N-1];
    int          bv [N-1];
    longint      cv;

    tcu_dot_top #(
        .N (N)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .fmt        (fmt),
        .a_rows     (a_rows),
        .b_cols     (b_cols),
        .c_val      (c_val),
        .ack        (ack),
        .result     (result),
        .exceptions (exceptions)
    );

    always #5 clk = ~clk;

    // galois lfsr, one output bit per step
    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r = (r << 1) | {31'h0, lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'ha300_0000;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return r;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = rand_bits(10);
        return lo + (r % (hi - lo + 1));
    endfunction

    // small integer to fp16 or bf16, always exact here
    function automatic tcu_pkg::half_t half_of(input int v, input tcu_pkg::fmt_e f);
        logic        s;
        logic [31:0] mag;
        logic [31:0] m;
        int          p;
        if (v == 0) begin
            return '0;
        end
        s   = (v < 0);
        mag = s ? -v : v;
        p   = 0;
        for (int i = 0; i < 32; i++) begin
            if (mag[i]) begin
                p = i;
            end
        end
        if (f == tcu_pkg::FMT_BF16) begin
            m = mag << (7 - p);
            return {s, 8'(127 + p), m[6:0]};
        end
        m = mag << (10 - p);
        return {s, 5'(15 + p), m[9:0]};
    endfunction

    // integer to fp32, bits below the mantissa dropped
    function automatic tcu_pkg::word_t fp32_of(input longint v);
        logic        s;
        logic [63:0] mag;
        logic [63:0] m;
        int          p;
        if (v == 0) begin
            return '0;
        end
        s   = (v < 0);
        mag = s ? -v : v;
        p   = 0;
        for (int i = 0; i < 64; i++) begin
            if (mag[i]) begin
                p = i;
            end
        end
        if (p >= 23) begin
            m = mag >> (p - 23);
        end else begin
            m = mag << (23 - p);
        end
        return {s, 8'(127 + p), m[22:0]};
    endfunction

    // exact dot product plus addend
    function automatic longint dot_ref();
        longint acc;
        acc = cv;
        for (int i = 0; i < N - 1; i++) begin
            acc = acc + longint'(av[i]) * longint'(bv[i]);
        end
        return acc;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string what, input tcu_pkg::word_t exp,
                              input tcu_pkg::word_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %0t: %s expected %h got %h", $time, what, exp, act));
        end
    endtask

    task automatic check_exc(input string what, input tcu_pkg::exc_t exp,
                             input tcu_pkg::exc_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %0t: %s flags expected %b got %b", $time, what, exp, act));
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %0t: %s expected %b got %b", $time, what, exp, act));
        end
    endtask

    task automatic wait_ack(input logic level, input string what);
        int count;
        count = 0;
        while (ack !== level && count < WAIT_MAX) begin
            @(posedge clk);
            #1;
            count++;
        end
        if (ack !== level) begin
            abort_run($sformatf("ack did not go to %0b within %0d cycles %s",
                                level, WAIT_MAX, what));
        end
    endtask

    // one full four-phase transfer
    task automatic run_dot(input tcu_pkg::fmt_e f, input tcu_pkg::half_t [N-2:0] a,
                           input tcu_pkg::half_t [N-2:0] b, input tcu_pkg::word_t c,
                           output tcu_pkg::word_t res, output tcu_pkg::exc_t exc);
        wait_ack(1'b0, "before a new request");
        fmt    = f;
        a_rows = a;
        b_cols = b;
        c_val  = c;
        req    = 1'b1;
        wait_ack(1'b1, "waiting for the result");
        res = result;
        exc = exceptions;
        req = 1'b0;
        wait_ack(1'b0, "after req was dropped");
    endtask

    task automatic run_int_case(input tcu_pkg::fmt_e f, input string what);
        tcu_pkg::half_t [N-2:0] a;
        tcu_pkg::half_t [N-2:0] b;
        tcu_pkg::word_t         res;
        tcu_pkg::exc_t          exc;
        tcu_pkg::word_t         want;
        for (int i = 0; i < N - 1; i++) begin
            a[i] = half_of(av[i], f);
            b[i] = half_of(bv[i], f);
        end
        want = fp32_of(dot_ref());
        run_dot(f, a, b, fp32_of(cv), res, exc);
        check_word(what, want, res);
        check_exc(what, '0, exc);
    endtask

    task automatic test_handshake();
        tcu_pkg::word_t want;
        check_bit("ack after reset", 1'b0, ack);
        check_word("result after reset", '0, result);
        check_exc("flags after reset", '0, exceptions);
        av   = '{1, 1, 1, 1};
        bv   = '{2, 3, 1, 1};
        cv   = 0;
        want = fp32_of(dot_ref());
        fmt  = tcu_pkg::FMT_FP16;
        for (int i = 0; i < N - 1; i++) begin
            a_rows[i] = half_of(av[i], tcu_pkg::FMT_FP16);
            b_cols[i] = half_of(bv[i], tcu_pkg::FMT_FP16);
        end
        c_val = fp32_of(cv);
        req   = 1'b1;
        // first edge sees req, third edge raises ack
        for (int e = 1; e <= 3; e++) begin
            @(posedge clk);
            #1;
            check_bit($sformatf("ack after edge %0d", e), e == 3, ack);
        end
        check_word("handshake result", want, result);
        check_exc("handshake flags", '0, exceptions);
        repeat (10) begin
            @(posedge clk);
            #1;
            check_bit("ack while req held", 1'b1, ack);
            check_word("result while req held", want, result);
            check_exc("flags while req held", '0, exceptions);
        end
        req = 1'b0;
        wait_ack(1'b0, "after req dropped in handshake test");
    endtask

    task automatic test_random(input tcu_pkg::fmt_e f, input string what);
        for (int k = 0; k < 20; k++) begin
            for (int i = 0; i < N - 1; i++) begin
                av[i] = rand_range(-15, 15);
                bv[i] = rand_range(-15, 15);
            end
            cv = longint'(rand_range(-255, 255));
            run_int_case(f, $sformatf("%s case %0d", what, k));
        end
    endtask

    task automatic test_bf16_edges();
        // zero operands in several lanes
        av = '{0, 3, 0, -2};
        bv = '{5, 0, 7, 4};
        cv = 10;
        run_int_case(tcu_pkg::FMT_BF16, "bf16 zero operands");
        // products cancel the addend, expect +0
        av = '{3, -2, 1, 0};
        bv = '{4, 5, -1, 9};
        cv = -1;
        run_int_case(tcu_pkg::FMT_BF16, "bf16 cancellation");
    endtask

    task automatic test_alignment();
        av = '{1, -1, 2, 1};
        bv = '{1, 2, -1, -2};
        cv = longint'(1) << 20;
        run_int_case(tcu_pkg::FMT_FP16, "addend 2^20");
        // large negative addend, truncation toward zero
        av = '{3, 2, -1, 1};
        bv = '{5, 7, 4, 1};
        cv = -(longint'(1) << 40);
        run_int_case(tcu_pkg::FMT_FP16, "addend -2^40 plus");
        bv = '{-5, -7, -4, -1};
        run_int_case(tcu_pkg::FMT_FP16, "addend -2^40 minus");
    endtask

    task automatic test_exceptions();
        tcu_pkg::half_t [N-2:0] a;
        tcu_pkg::half_t [N-2:0] b;
        tcu_pkg::word_t         res;
        tcu_pkg::exc_t          exc;
        tcu_pkg::exc_t          want;
        a    = {(N - 1){H_ONE}};
        b    = {(N - 1){H_ONE}};
        a[0] = H_QNAN;
        want = '0;
        want.nan = 1'b1;
        run_dot(tcu_pkg::FMT_FP16, a, b, '0, res, exc);
        check_exc("nan operand", want, exc);
        check_word("nan operand", W_QNAN, res);
        // +inf times -2 gives -inf
        a[0] = H_PINF;
        b[0] = H_MTWO;
        want = '0;
        want.inf = 1'b1;
        run_dot(tcu_pkg::FMT_FP16, a, b, '0, res, exc);
        check_exc("inf times finite", want, exc);
        check_word("inf times finite", W_NINF, res);
        b[0] = '0;
        want = '0;
        want.invalid = 1'b1;
        run_dot(tcu_pkg::FMT_FP16, a, b, '0, res, exc);
        check_exc("inf times zero", want, exc);
        check_word("inf times zero", W_QNAN, res);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        req        = 1'b0;
        fmt        = tcu_pkg::FMT_FP16;
        a_rows     = '0;
        b_cols     = '0;
        c_val      = '0;
        lfsr_state = 32'd94669;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        test_handshake();
        test_random(tcu_pkg::FMT_FP16, "fp16");
        test_random(tcu_pkg::FMT_BF16, "bf16");
        test_bf16_edges();
        test_alignment();
        test_exceptions();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire
